// File: include/macros.svh
// Lane selects assume lane 0 sits in the low bits and the lane index stays in range
`ifndef MACROS_SVH
`define MACROS_SVH

// Lane n of a packed INT8 vector
// Works with a variable n, since the part-select width is fixed
`define LANE8(vec, n) vec[(n)*8 +: 8]

// Lane n of a packed 16-bit vector
// Used for accumulator results and the read mux
`define LANE16(vec, n) vec[(n)*16 +: 16]

`endif

// File: verilog/mini_core_accel_pkg.sv
// Fixed 4x4 INT8 geometry; skew, lane packing and timing all assume DIM of 4
package mini_core_accel_pkg;

    localparam int DIM        = 4;              // Grid side
    localparam int DATA_W     = 8;              // INT8 operands
    localparam int ACC_W      = 16;             // Wrapping accumulator width
    localparam int SKEW_STEPS = 2*DIM - 1;      // Diagonal wavefront length
    localparam int STEP_W     = $clog2(SKEW_STEPS + 1);  // Counter must reach SKEW_STEPS
    localparam int LANE_W     = DIM * DATA_W;   // One packed operand row or column
    localparam int RES_W      = DIM * DIM * ACC_W;       // All accumulators packed

    // Operands and done entering a PE
    typedef struct packed {
        logic [DATA_W-1:0] weight;
        logic [DATA_W-1:0] activation;
        logic              done;
    } t_pe_unit_input;

    // Same fields registered toward the neighbors
    typedef struct packed {
        logic [DATA_W-1:0] weight;
        logic [DATA_W-1:0] activation;
        logic              done;
    } t_pe_unit_output;

    // Write target select
    typedef enum logic {
        MAT_ACT = 1'b0,     // Activation matrix A
        MAT_WGT = 1'b1      // Weight matrix B
    } t_mat_sel;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,              // Zero the array
        FEED,               // Skewed operands on the lanes
        DRAIN,              // Wait for results to settle and be captured
        DONE
    } t_ctrl_state;

endpackage

// File: verilog/array_feed_if.sv
// Skewer-to-array bus with no handshake; the array consumes every cycle
`timescale 1ns/1ps

interface array_feed_if;
    import mini_core_accel_pkg::*;

    logic [LANE_W-1:0] weights;     // Lane c enters the top of column c
    logic [LANE_W-1:0] activation;  // Lane r enters the left of row r
    logic              first_done;  // Pulse into PE(0,0) with its last operands
    logic              clear;       // Level, zeroes every PE register
    logic              valid;       // Done has reached PE(3,3)

    // Operand source side
    modport skewer (
        output weights, activation, first_done, clear
    );

    // Grid side
    modport array (
        input  weights, activation, first_done, clear,
        output valid
    );

endinterface

// File: verilog/pe_unit.sv
// Signed INT8 MAC with a 16-bit accumulator that wraps; no saturation
`timescale 1ns/1ps

module pe_unit (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  clear,       // Zeroes acc and pass-through
    input  mini_core_accel_pkg::t_pe_unit_input   pe_inputs,
    output mini_core_accel_pkg::t_pe_unit_output  pe_outputs,
    output logic [mini_core_accel_pkg::ACC_W-1:0] result
);
    import mini_core_accel_pkg::*;

    logic signed [2*DATA_W-1:0] product;   // Full-precision signed product
    logic        [ACC_W-1:0]    acc;

    assign product = $signed(pe_inputs.weight) * $signed(pe_inputs.activation);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc        <= '0;
            pe_outputs <= '0;
        end else begin
            // Sign-extending cast, then modulo 2^ACC_W add
            acc <= acc + ACC_W'(product);

            // Forward operands one hop; weight goes down, activation goes right
            pe_outputs.weight     <= pe_inputs.weight;
            pe_outputs.activation <= pe_inputs.activation;
            pe_outputs.done       <= pe_inputs.done;  // Done moves one PE per cycle
        end
    end

    assign result = acc;

endmodule

// File: verilog/systolic_array_net.sv
// Output-stationary 4x4 grid; done must arrive at PE(0,0) with its last operand pair
`timescale 1ns/1ps
`include "macros.svh"

module systolic_array_net (
    input  logic                                  clk,
    input  logic                                  rst,
    array_feed_if.array                           feed,
    output logic [mini_core_accel_pkg::RES_W-1:0] results  // PE(r,c) in lane r*DIM+c
);
    import mini_core_accel_pkg::*;

    t_pe_unit_input  unit_in  [DIM][DIM];
    t_pe_unit_output unit_out [DIM][DIM];
    logic [ACC_W-1:0] pe_result [DIM][DIM];
    logic             done_in   [DIM][DIM];  // Done seen by each PE

    genvar row, col;
    generate
        for (row = 0; row < DIM; row++) begin : g_row
            for (col = 0; col < DIM; col++) begin : g_col
                // Edge PEs take the lanes, inner PEs take the neighbor registers
                if (row == 0) begin : g_w_top
                    assign unit_in[row][col].weight = `LANE8(feed.weights, col);
                end else begin : g_w_inner
                    assign unit_in[row][col].weight = unit_out[row-1][col].weight;
                end

                if (col == 0) begin : g_a_left
                    assign unit_in[row][col].activation = `LANE8(feed.activation, row);
                end else begin : g_a_inner
                    assign unit_in[row][col].activation = unit_out[row][col-1].activation;
                end

                // Done wavefront follows the operand diagonal
                if (row == 0 && col == 0) begin : g_d_origin
                    assign done_in[row][col] = feed.first_done;
                end else if (row == 0) begin : g_d_top
                    assign done_in[row][col] = unit_out[row][col-1].done;  // From the left
                end else if (col == 0) begin : g_d_left
                    assign done_in[row][col] = unit_out[row-1][col].done;  // From above
                end else begin : g_d_inner
                    assign done_in[row][col] = unit_out[row-1][col].done |
                                               unit_out[row][col-1].done;
                end

                assign unit_in[row][col].done = done_in[row][col];

                pe_unit u_pe (
                    .clk        (clk),
                    .rst        (rst),
                    .clear      (feed.clear),
                    .pe_inputs  (unit_in[row][col]),
                    .pe_outputs (unit_out[row][col]),
                    .result     (pe_result[row][col])
                );

                assign `LANE16(results, row*DIM + col) = pe_result[row][col];
            end
        end
    endgenerate

    // Far corner sees done with its last operands, one cycle before its final add
    assign feed.valid = done_in[DIM-1][DIM-1];

endmodule

// File: verilog/operand_skewer.sv
// Lanes are registered one cycle ahead of use, so feed_en must rise during CLEAR
`timescale 1ns/1ps
`include "macros.svh"

module operand_skewer (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   wr_en,
    input  mini_core_accel_pkg::t_mat_sel          wr_sel,
    input  logic [1:0]                             wr_row,
    input  logic [mini_core_accel_pkg::LANE_W-1:0] wr_data,   // Lane k is element k
    input  logic                                   busy,      // Blocks buffer writes
    input  logic                                   clear_acc,
    input  logic                                   feed_en,
    output logic                                   feed_end,  // High with the last step
    array_feed_if.skewer                           feed
);
    import mini_core_accel_pkg::*;

    logic [LANE_W-1:0] a_buf [DIM];   // Row r of A
    logic [LANE_W-1:0] b_buf [DIM];   // Row k of B
    logic [STEP_W-1:0] step;          // Step that the next lane load presents
    logic [LANE_W-1:0] act_next;
    logic [LANE_W-1:0] wgt_next;

    // Host writes, ignored while an operation runs
    always_ff @(posedge clk) begin
        if (wr_en && !busy) begin
            if (wr_sel == MAT_ACT) begin
                a_buf[wr_row] <= wr_data;
            end else begin
                b_buf[wr_row] <= wr_data;
            end
        end
    end

    // Counts while feeding, parks at SKEW_STEPS so the lanes go to zero
    always_ff @(posedge clk) begin
        if (rst || !feed_en) begin
            step <= '0;
        end else if (step != STEP_W'(SKEW_STEPS)) begin
            step <= step + 1'b1;
        end
    end

    // Diagonal skew, row r lags by r steps and column c lags by c steps
    always_comb begin
        int k;
        act_next = '0;
        wgt_next = '0;
        for (int i = 0; i < DIM; i++) begin
            k = int'(step) - i;
            if (feed_en && k >= 0 && k < DIM) begin
                `LANE8(act_next, i) = `LANE8(a_buf[i], k);   // A[i][step-i]
                `LANE8(wgt_next, i) = `LANE8(b_buf[k], i);   // B[step-i][i]
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            feed.activation <= '0;
            feed.weights    <= '0;
            feed.first_done <= 1'b0;
            feed_end        <= 1'b0;
        end else begin
            feed.activation <= act_next;   // Zero outside the wavefront
            feed.weights    <= wgt_next;
            feed.first_done <= feed_en && (step == STEP_W'(DIM-1));  // Last pair for PE(0,0)
            feed_end        <= feed_en && (step == STEP_W'(SKEW_STEPS-1));
        end
    end

    assign feed.clear = clear_acc;  // Same cycle as the controller's CLEAR state

endmodule

// File: verilog/accel_ctrl.sv
// Fixed sequence with no abort; start is sampled only in IDLE
`timescale 1ns/1ps

module accel_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic feed_end,    // Skewer finished its last step
    input  logic captured,    // Result bank latched the array
    output logic clear_acc,
    output logic feed_en,
    output logic busy,
    output logic done
);
    import mini_core_accel_pkg::*;

    t_ctrl_state state;
    t_ctrl_state state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    state_next = CLEAR;
                end
            end
            CLEAR:   state_next = FEED;   // One cycle of clear
            FEED: begin
                if (feed_end) begin
                    state_next = DRAIN;
                end
            end
            DRAIN: begin
                // Done still crossing the grid
                if (captured) begin
                    state_next = DONE;
                end
            end
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    assign clear_acc = (state == CLEAR);
    // Skewer loads step 0 during CLEAR so it is on the lanes in the first FEED cycle
    assign feed_en   = (state == CLEAR) || (state == FEED);
    assign busy      = (state != IDLE);
    assign done      = (state == DONE);   // Single-cycle pulse

endmodule

// File: verilog/result_bank.sv
// Results hold until the next capture; read data lags the address by one cycle
`timescale 1ns/1ps
`include "macros.svh"

module result_bank (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [mini_core_accel_pkg::RES_W-1:0] results,
    input  logic                                  valid,     // Done at the last PE
    input  logic [1:0]                            rd_row,
    input  logic [1:0]                            rd_col,
    output logic [mini_core_accel_pkg::ACC_W-1:0] rd_data,
    output logic                                  captured
);
    import mini_core_accel_pkg::*;

    logic             valid_d;   // Last PE has made its final add
    logic [RES_W-1:0] bank;
    int               rd_idx;

    assign rd_idx = int'(rd_row) * DIM + int'(rd_col);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_d <= 1'b0;
            bank    <= '0;      // Reads return zero before the first operation
            rd_data <= '0;
        end else begin
            valid_d <= valid;
            if (valid_d) begin
                bank <= results;  // Whole array in one cycle
            end
            rd_data <= `LANE16(bank, rd_idx);
        end
    end

    // Same strobe tells the controller the latch is done
    assign captured = valid_d;

endmodule

// File: verilog/mini_core_accel.sv
// Plain strobe interface, no bus protocol; fixed 13-cycle start-to-done latency
`timescale 1ns/1ps

module mini_core_accel (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  mini_core_accel_pkg::t_mat_sel wr_sel,
    input  logic [1:0]                    wr_row,
    input  logic [31:0]                   wr_data,
    input  logic                          start,
    input  logic [1:0]                    rd_row,
    input  logic [1:0]                    rd_col,
    output logic [15:0]                   rd_data,
    output logic                          busy,
    output logic                          done
);

    logic         clear_acc;
    logic         feed_en;
    logic         feed_end;
    logic         captured;
    logic [255:0] results;       // 16 packed accumulators

    array_feed_if feed_bus ();

    accel_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .feed_end  (feed_end),
        .captured  (captured),
        .clear_acc (clear_acc),
        .feed_en   (feed_en),
        .busy      (busy),
        .done      (done)
    );

    operand_skewer u_skewer (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .wr_row    (wr_row),
        .wr_data   (wr_data),
        .busy      (busy),
        .clear_acc (clear_acc),
        .feed_en   (feed_en),
        .feed_end  (feed_end),
        .feed      (feed_bus.skewer)
    );

    systolic_array_net u_array (
        .clk     (clk),
        .rst     (rst),
        .feed    (feed_bus.array),
        .results (results)
    );

    result_bank u_bank (
        .clk      (clk),
        .rst      (rst),
        .results  (results),
        .valid    (feed_bus.valid),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_data  (rd_data),
        .captured (captured)
    );

endmodule

// File: tests/accel_checker.sv
// Watches DUT ports only; the timing model assumes the fixed 13-cycle start-to-done latency
`timescale 1ns/1ps

module accel_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  mini_core_accel_pkg::t_mat_sel wr_sel,
    input  logic [1:0]                    wr_row,
    input  logic [31:0]                   wr_data,
    input  logic                          start,
    input  logic [1:0]                    rd_row,
    input  logic [1:0]                    rd_col,
    input  logic [15:0]                   rd_data,
    input  logic                          busy,
    input  logic                          done,
    output int                            errors
);
    import mini_core_accel_pkg::*;

    logic [31:0] a_mirror [4];      // Accepted rows of A
    logic [31:0] b_mirror [4];      // Accepted rows of B
    logic [15:0] pending  [16];     // Model C of the running operation
    logic [15:0] shown    [16];     // Model of what the read port serves
    logic [15:0] exp_data;          // For the address of the previous cycle
    logic [1:0]  exp_row;
    logic [1:0]  exp_col;
    logic        exp_valid;
    logic        exp_busy;          // Model busy for the sampled cycle
    logic        exp_done;
    int          op_cycle;          // Cycle of the running operation, 0 when idle

    // C[i][j] = sum of signed A[i][k]*B[k][j], modulo 2^16
    function automatic logic [15:0] dot_product(input int i, input int j);
        logic signed [7:0] a_el;
        logic signed [7:0] b_el;
        int                sum;
        sum = 0;
        for (int k = 0; k < 4; k++) begin
            a_el = a_mirror[i][k*8 +: 8];
            b_el = b_mirror[k][j*8 +: 8];
            sum  = sum + int'(a_el) * int'(b_el);
        end
        return sum[15:0];
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int n = 0; n < 16; n++) begin
                pending[n] = '0;
                shown[n]   = '0;
            end
            for (int r = 0; r < 4; r++) begin
                a_mirror[r] = '0;
                b_mirror[r] = '0;
            end
            exp_valid = 1'b0;
            op_cycle  = 0;
            errors    = 0;
        end else begin
            // Busy from the cycle after the start edge through cycle 13, done in cycle 13
            exp_busy = (op_cycle >= 1 && op_cycle <= 13);
            exp_done = (op_cycle == 13);
            if (busy !== exp_busy) begin
                errors++;
                $display("Fail busy: got %h, expected %h", busy, exp_busy);
            end
            if (done !== exp_done) begin
                errors++;
                $display("Fail done: got %h, expected %h", done, exp_done);
            end

            if (exp_valid && rd_data !== exp_data) begin
                errors++;
                $display("Fail rd_data row %0d col %0d: got %h, expected %h",
                         exp_row, exp_col, rd_data, exp_data);
            end

            // Bank already holds the new results in the done cycle
            if (exp_done) begin
                shown = pending;
            end

            if (wr_en && !exp_busy) begin   // Writes while busy are dropped
                if (wr_sel == MAT_ACT) begin
                    a_mirror[wr_row] = wr_data;
                end else begin
                    b_mirror[wr_row] = wr_data;
                end
            end

            if (start && !exp_busy) begin   // Only IDLE accepts start
                for (int n = 0; n < 16; n++) begin
                    pending[n] = dot_product(n / 4, n % 4);
                end
                op_cycle = 1;
            end else if (exp_busy && !exp_done) begin
                op_cycle++;
            end else begin
                op_cycle = 0;               // Back to IDLE after the done cycle
            end

            exp_data  = shown[int'(rd_row) * 4 + int'(rd_col)];
            exp_row   = rd_row;
            exp_col   = rd_col;
            exp_valid = 1'b1;
        end
    end

endmodule

// File: tests/accel_assert.sv
// Bound into accel_ctrl; captured there is the result bank's strobe
`timescale 1ns/1ps

module accel_assert (
    input logic                             clk,
    input logic                             rst,
    input logic                             start,
    input mini_core_accel_pkg::t_ctrl_state state,
    input logic                             busy,
    input logic                             done,
    input logic                             captured
);
    import mini_core_accel_pkg::*;

    // One-cycle done pulse
    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for more than one cycle");

    done_after_busy: assert property (@(posedge clk) disable iff (rst) done |-> $past(busy))
        else $error("done without busy in the cycle before");

    // Bank latch only while draining
    captured_in_drain: assert property (@(posedge clk) disable iff (rst)
        captured |-> state == DRAIN)
        else $error("captured outside DRAIN");

    // Leaving IDLE needs a start and goes through CLEAR
    active_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> state == CLEAR && $past(start))
        else $error("busy rose without a start or outside CLEAR");

endmodule

bind accel_ctrl accel_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .state    (state),
    .busy     (busy),
    .done     (done),
    .captured (captured)
);

// File: tests/tb_mini_core_accel.sv
// Fixed-seed random and corner matrices; accel_checker does all the comparing
`timescale 1ns/1ps

module tb_mini_core_accel;
    import mini_core_accel_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        wr_en;
    t_mat_sel    wr_sel;
    logic [1:0]  wr_row;
    logic [31:0] wr_data;
    logic        start;
    logic [1:0]  rd_row;
    logic [1:0]  rd_col;
    logic [15:0] rd_data;
    logic        busy;
    logic        done;

    logic [31:0]  lfsr_state;       // Stepped once per random bit
    logic [127:0] mat_a;            // Row r in bits r*32 +: 32
    logic [127:0] mat_b;
    int           check_errors;     // From the checker
    int           timeouts;

    always #4 clk = ~clk;           // 8 ns period

    mini_core_accel u_mini_core_accel (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_row  (wr_row),
        .wr_data (wr_data),
        .start   (start),
        .rd_row  (rd_row),
        .rd_col  (rd_col),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done)
    );

    accel_checker u_checker (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_sel  (wr_sel),
        .wr_row  (wr_row),
        .wr_data (wr_data),
        .start   (start),
        .rd_row  (rd_row),
        .rd_col  (rd_col),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done),
        .errors  (check_errors)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};  // One step per bit
        end
    endtask

    task automatic draw_matrix(output logic [127:0] m);
        logic [31:0] row;
        for (int r = 0; r < 4; r++) begin
            draw_bits(32, row);
            m[r*32 +: 32] = row;
        end
    endtask

    // One row per cycle
    task automatic load_matrix(input t_mat_sel sel, input logic [127:0] m);
        for (int r = 0; r < 4; r++) begin
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_sel  <= sel;
            wr_row  <= 2'(r);
            wr_data <= m[r*32 +: 32];
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic wait_done;
        int cycles;
        cycles = 0;
        while (!done && cycles < 40) begin
            @(negedge clk);         // Sample away from the drive edge
            cycles++;
        end
        if (!done) begin
            timeouts++;
            $display("Timeout: done did not arrive within 40 cycles of start");
        end
    endtask

    task automatic run_op;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_done();
    endtask

    // Walk all 16 addresses; checker compares each cycle
    task automatic read_sweep;
        for (int a = 0; a < 16; a++) begin
            @(posedge clk);
            rd_row <= 2'(a / 4);
            rd_col <= 2'(a % 4);
        end
        repeat (2) @(posedge clk);
    endtask

    // Writes and a second start while busy, all to be ignored
    task automatic run_disturbed_op;
        logic [31:0] row;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < 6; i++) begin
            draw_bits(32, row);
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_sel  <= (i % 2 == 0) ? MAT_ACT : MAT_WGT;
            wr_row  <= 2'(i);
            wr_data <= row;
            start   <= (i == 3);
        end
        @(posedge clk);
        wr_en <= 1'b0;
        start <= 1'b0;
        wait_done();
    endtask

    initial begin
        lfsr_state = 32'h5d76_5277;
        timeouts   = 0;
        rst        = 1'b1;
        wr_en      = 1'b0;
        wr_sel     = MAT_ACT;
        wr_row     = '0;
        wr_data    = '0;
        start      = 1'b0;
        rd_row     = '0;
        rd_col     = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        read_sweep();               // Zeros after reset

        // Back-to-back random operations
        repeat (3) begin
            draw_matrix(mat_a);
            draw_matrix(mat_b);
            load_matrix(MAT_ACT, mat_a);
            load_matrix(MAT_WGT, mat_b);
            run_op();
            read_sweep();
        end

        draw_matrix(mat_a);
        draw_matrix(mat_b);
        load_matrix(MAT_ACT, mat_a);
        load_matrix(MAT_WGT, mat_b);
        run_disturbed_op();
        repeat (5) @(posedge clk);  // Room for a stray done
        read_sweep();

        // Signed extremes, products wrap in 16 bits
        load_matrix(MAT_ACT, {16{8'h80}});
        load_matrix(MAT_WGT, {16{8'h80}});
        run_op();
        read_sweep();
        load_matrix(MAT_ACT, {16{8'h7f}});
        load_matrix(MAT_WGT, {16{8'h7f}});
        run_op();
        read_sweep();
        load_matrix(MAT_ACT, {16{8'h80}});
        run_op();
        read_sweep();

        // Results must hold over idle time and new writes
        repeat (10) @(posedge clk);
        draw_matrix(mat_a);
        draw_matrix(mat_b);
        load_matrix(MAT_ACT, mat_a);
        load_matrix(MAT_WGT, mat_b);
        read_sweep();

        repeat (2) @(posedge clk);
        $display("Errors: %0d compare, %0d timeout", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: mini_core_accel.f
+incdir+include
verilog/mini_core_accel_pkg.sv
verilog/array_feed_if.sv
verilog/pe_unit.sv
verilog/systolic_array_net.sv
verilog/operand_skewer.sv
verilog/accel_ctrl.sv
verilog/result_bank.sv
verilog/mini_core_accel.sv
tests/accel_checker.sv
tests/accel_assert.sv
tests/tb_mini_core_accel.sv

// File: Makefile
TOP := tb_mini_core_accel
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f mini_core_accel.f --top-module $(TOP)
	verilator --lint-only -f mini_core_accel.f -Iinclude --top-module mini_core_accel \
		verilog/mini_core_accel.sv

sim:
	verilator --binary --timing --assert -f mini_core_accel.f --top-module $(TOP) \
		-o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
